//--- src/pid_pkg.sv
`default_nettype none

// ---------------------------------------------------------------------------
// Shared widths, configuration map and configuration word layout
// ---------------------------------------------------------------------------
package pid_pkg;

   // Source number carried with every ADC sample
   localparam int W_SRC = 5;
   // Signed ADC sample width
   localparam int W_DATA = 18;
   // Configuration data word width
   localparam int W_CFG = 32;
   // Signed channel result width
   localparam int W_RESULT = 32;
   // Width of a configuration address
   localparam int W_CFG_ADDR = 4;

   // Gain is signed and fills the coefficient word above the setpoint
   localparam int W_GAIN = W_CFG - W_DATA;
   // Error carries one extra bit so that sample minus setpoint never wraps
   localparam int W_ERR = W_DATA + 1;

   // Address whose data word is read through the route view
   localparam logic [W_CFG_ADDR-1:0] CFG_ADDR_ROUTE = 4'h1;
   // Address whose data word is read through the coefficient view
   localparam logic [W_CFG_ADDR-1:0] CFG_ADDR_COEF = 4'h2;

   // Route view of a configuration word
   // A set null_src means the channel listens to no source at all
   typedef struct packed {
      logic [W_CFG-W_SRC-3:0] rsvd;
      logic en;
      logic null_src;
      logic [W_SRC-1:0] src;
   } cfg_route_t;

   // Coefficient view, gain in the upper bits and setpoint in the lower
   typedef struct packed {
      logic signed [W_GAIN-1:0] gain;
      logic signed [W_DATA-1:0] setpoint;
   } cfg_coef_t;

   // One written word, decoded by address as either a route or coefficients
   typedef union packed {
      cfg_route_t route;
      cfg_coef_t coef;
   } cfg_word_u;

endpackage

`default_nettype wire

//--- src/adc_fifo.sv
`default_nettype none

// Circular buffer for source-tagged ADC samples
// The head word is read straight out of storage, and valid trails a
// write into an empty buffer by one cycle
module adc_fifo
   import pid_pkg::*;
#(
   parameter int FIFO_DEPTH = 16
) (
   input  logic clk_in,
   input  logic rst,
   input  logic wr_en,
   input  logic [W_SRC-1:0] wr_src,
   input  logic signed [W_DATA-1:0] wr_data,
   input  logic pop,
   output logic valid,
   output logic [W_SRC-1:0] head_src,
   output logic signed [W_DATA-1:0] head_data,
   output logic overflow
);

   localparam int W_PTR = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int W_CNT = $clog2(FIFO_DEPTH + 1);

   logic [W_SRC+W_DATA-1:0] mem [FIFO_DEPTH];
   logic [W_PTR-1:0] wr_ptr;
   logic [W_PTR-1:0] rd_ptr;
   logic [W_CNT-1:0] count;
   logic full;
   logic do_wr;
   logic do_pop;

   // Pointers wrap explicitly so that any depth works
   function automatic logic [W_PTR-1:0] ptr_inc(input logic [W_PTR-1:0] p);
      return (p == W_PTR'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // A full buffer refuses the write even when the head pops in the same cycle
   assign full = (count == W_CNT'(FIFO_DEPTH));
   assign do_wr = wr_en && !full;
   assign do_pop = pop && valid;

   always_ff @(posedge clk_in) begin
      if (do_wr) begin
         mem[wr_ptr] <= {wr_src, wr_data};
      end
   end

   always_ff @(posedge clk_in) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         valid <= 1'b0;
         overflow <= 1'b0;
      end else begin
         // One pulse for every dropped word
         overflow <= wr_en && full;
         if (do_wr) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({do_wr, do_pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
         // Valid looks at the occupancy before this edge, which delays a
         // fresh word by one cycle. Popping the last word clears it
         valid <= (count != '0) && !(do_pop && count == W_CNT'(1));
      end
   end

   assign {head_src, head_data} = mem[rd_ptr];

endmodule

`default_nettype wire

//--- src/instr_dispatch.sv
`default_nettype none

// Turns each buffered sample into one instruction per routed channel
// Channels are served lowest first, and the head is popped only once every
// routed channel has had its slot
module instr_dispatch
   import pid_pkg::*;
#(
   parameter int N_CHAN = 8,
   parameter int W_CHAN = 3
) (
   input  logic clk_in,
   input  logic rst,
   input  logic fifo_valid,
   input  logic [W_SRC-1:0] fifo_src,
   input  logic signed [W_DATA-1:0] fifo_data,
   output logic fifo_pop,
   input  logic cfg_wr,
   input  logic [W_CFG_ADDR-1:0] cfg_addr,
   input  logic [W_CHAN-1:0] cfg_chan,
   input  logic [W_CFG-1:0] cfg_data,
   output logic instr_dv,
   output logic [W_CHAN-1:0] instr_chan,
   output logic signed [W_DATA-1:0] instr_data
);

   // ---------------------------------------------------------------------------
   // Routing table
   // ---------------------------------------------------------------------------
   logic [W_SRC-1:0] route_src [N_CHAN];
   logic [N_CHAN-1:0] route_null;
   logic [N_CHAN-1:0] chan_en;
   cfg_word_u cfg_word;

   assign cfg_word = cfg_data;

   // Reset leaves every channel unrouted and inactive
   always_ff @(posedge clk_in) begin
      if (rst) begin
         route_null <= '1;
         chan_en <= '0;
         for (int i = 0; i < N_CHAN; i++) begin
            route_src[i] <= '0;
         end
      end else if (cfg_wr && cfg_addr == CFG_ADDR_ROUTE && int'(cfg_chan) < N_CHAN) begin
         route_src[cfg_chan] <= cfg_word.route.src;
         route_null[cfg_chan] <= cfg_word.route.null_src;
         chan_en[cfg_chan] <= cfg_word.route.en;
      end
   end

   // ---------------------------------------------------------------------------
   // Channel search
   // ---------------------------------------------------------------------------
   logic [N_CHAN-1:0] served;
   logic [N_CHAN-1:0] hit;
   logic found;
   logic [W_CHAN-1:0] sel;

   // A channel is a candidate when it listens to the head source and has not
   // been given this word yet. Enable plays no part here
   always_comb begin
      for (int i = 0; i < N_CHAN; i++) begin
         hit[i] = !route_null[i] && route_src[i] == fifo_src && !served[i];
      end
   end

   // Scanning downward lets the lowest candidate win
   always_comb begin
      found = 1'b0;
      sel = '0;
      for (int i = N_CHAN - 1; i >= 0; i--) begin
         if (hit[i]) begin
            found = 1'b1;
            sel = W_CHAN'(i);
         end
      end
   end

   // The head leaves in the same cycle that the search comes up empty
   assign fifo_pop = fifo_valid && !found;

   // ---------------------------------------------------------------------------
   // Instruction issue
   // ---------------------------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (rst) begin
         served <= '0;
         instr_dv <= 1'b0;
      end else if (fifo_valid && found) begin
         // A disabled channel still takes its slot but raises no strobe
         served[sel] <= 1'b1;
         instr_dv <= chan_en[sel];
      end else begin
         // Either the word is finished or nothing is waiting
         served <= '0;
         instr_dv <= 1'b0;
      end
   end

   always_ff @(posedge clk_in) begin
      if (fifo_valid && found) begin
         instr_chan <= sel;
         instr_data <= fifo_data;
      end
   end

endmodule

`default_nettype wire

//--- src/pid_channel.sv
`default_nettype none

// One proportional-plus-integral channel
// Stage one forms the error against the setpoint, and stage two updates the
// integrator and adds the proportional term. All sums wrap
module pid_channel
   import pid_pkg::*;
#(
   parameter int CHAN_ID = 0,
   parameter int W_CHAN = 3
) (
   input  logic clk_in,
   input  logic rst,
   input  logic instr_dv,
   input  logic [W_CHAN-1:0] instr_chan,
   input  logic signed [W_DATA-1:0] instr_data,
   input  logic cfg_wr,
   input  logic [W_CFG_ADDR-1:0] cfg_addr,
   input  logic [W_CHAN-1:0] cfg_chan,
   input  logic [W_CFG-1:0] cfg_data,
   output logic res_dv,
   output logic signed [W_RESULT-1:0] res_value
);

   // ---------------------------------------------------------------------------
   // Coefficients
   // ---------------------------------------------------------------------------
   cfg_word_u cfg_word;
   logic signed [W_DATA-1:0] setpoint;
   logic signed [W_GAIN-1:0] gain;

   assign cfg_word = cfg_data;

   always_ff @(posedge clk_in) begin
      if (rst) begin
         setpoint <= '0;
         gain <= '0;
      end else if (cfg_wr && cfg_addr == CFG_ADDR_COEF && cfg_chan == W_CHAN'(CHAN_ID)) begin
         setpoint <= cfg_word.coef.setpoint;
         gain <= cfg_word.coef.gain;
      end
   end

   // ---------------------------------------------------------------------------
   // Stage one
   // ---------------------------------------------------------------------------
   logic chan_hit;
   logic s1_dv;
   logic signed [W_ERR-1:0] s1_err;

   assign chan_hit = instr_dv && instr_chan == W_CHAN'(CHAN_ID);

   always_ff @(posedge clk_in) begin
      if (rst) begin
         s1_dv <= 1'b0;
      end else begin
         s1_dv <= chan_hit;
      end
   end

   // Both operands are widened by one sign bit before the subtraction
   always_ff @(posedge clk_in) begin
      if (chan_hit) begin
         s1_err <= {instr_data[W_DATA-1], instr_data} - {setpoint[W_DATA-1], setpoint};
      end
   end

   // ---------------------------------------------------------------------------
   // Stage two
   // ---------------------------------------------------------------------------
   logic signed [W_RESULT-1:0] integ;
   logic signed [W_RESULT-1:0] integ_next;
   logic signed [W_RESULT-1:0] err_ext;
   logic signed [W_GAIN+W_ERR-1:0] prod;

   assign err_ext = {{(W_RESULT - W_ERR){s1_err[W_ERR-1]}}, s1_err};
   assign integ_next = integ + err_ext;
   // Full product, only its low W_RESULT bits reach the output
   assign prod = gain * s1_err;

   always_ff @(posedge clk_in) begin
      if (rst) begin
         res_dv <= 1'b0;
         integ <= '0;
      end else begin
         res_dv <= s1_dv;
         if (s1_dv) begin
            integ <= integ_next;
         end
      end
   end

   always_ff @(posedge clk_in) begin
      if (s1_dv) begin
         res_value <= prod[W_RESULT-1:0] + integ_next;
      end
   end

endmodule

`default_nettype wire

//--- src/result_collector.sv
`default_nettype none

// Folds the per-channel result strobes onto one registered output stream
// The dispatcher issues at most one instruction per cycle and every channel
// has the same latency, so two strobes never meet. The lowest index would
// win if they did
module result_collector
   import pid_pkg::*;
#(
   parameter int N_CHAN = 8,
   parameter int W_CHAN = 3
) (
   input  logic clk_in,
   input  logic rst,
   input  logic [N_CHAN-1:0] res_dv,
   input  logic [N_CHAN-1:0][W_RESULT-1:0] res_value,
   output logic dv_out,
   output logic [W_CHAN-1:0] chan_out,
   output logic signed [W_RESULT-1:0] result_out
);

   logic any_dv;
   logic [W_CHAN-1:0] sel;
   logic [W_RESULT-1:0] sel_value;

   assign any_dv = |res_dv;

   // Encode the active strobe and pick its value
   always_comb begin
      sel = '0;
      sel_value = res_value[0];
      for (int i = N_CHAN - 1; i >= 0; i--) begin
         if (res_dv[i]) begin
            sel = W_CHAN'(i);
            sel_value = res_value[i];
         end
      end
   end

   // ---------------------------------------------------------------------------
   // Output register
   // ---------------------------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (rst) begin
         dv_out <= 1'b0;
      end else begin
         dv_out <= any_dv;
      end
   end

   // Channel and value hold their last result between strobes
   always_ff @(posedge clk_in) begin
      if (any_dv) begin
         chan_out <= sel;
         result_out <= sel_value;
      end
   end

endmodule

`default_nettype wire

//--- src/pid_top.sv
`default_nettype none

// PID dispatch subsystem
// Samples pass through the input FIFO and the dispatcher, fan out to the
// channel row and come back together in the collector
module pid_top
   import pid_pkg::*;
#(
   parameter int N_CHAN = 8,
   parameter int FIFO_DEPTH = 16,
   parameter int W_CHAN = 3
) (
   input  logic clk_in,
   input  logic rst,
   input  logic dv_in,
   input  logic [W_SRC-1:0] src_in,
   input  logic signed [W_DATA-1:0] data_in,
   input  logic cfg_wr,
   input  logic [W_CFG_ADDR-1:0] cfg_addr,
   input  logic [W_CHAN-1:0] cfg_chan,
   input  logic [W_CFG-1:0] cfg_data,
   output logic dv_out,
   output logic [W_CHAN-1:0] chan_out,
   output logic signed [W_RESULT-1:0] result_out,
   output logic overflow
);

   // FIFO head toward the dispatcher
   logic fifo_valid;
   logic [W_SRC-1:0] fifo_src;
   logic signed [W_DATA-1:0] fifo_data;
   logic fifo_pop;

   // Instruction broadcast to every channel
   logic instr_dv;
   logic [W_CHAN-1:0] instr_chan;
   logic signed [W_DATA-1:0] instr_data;

   // One strobe and one value per channel
   logic [N_CHAN-1:0] res_dv;
   logic [N_CHAN-1:0][W_RESULT-1:0] res_value;

   adc_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk_in    (clk_in),
      .rst       (rst),
      .wr_en     (dv_in),
      .wr_src    (src_in),
      .wr_data   (data_in),
      .pop       (fifo_pop),
      .valid     (fifo_valid),
      .head_src  (fifo_src),
      .head_data (fifo_data),
      .overflow  (overflow)
   );

   instr_dispatch #(
      .N_CHAN (N_CHAN),
      .W_CHAN (W_CHAN)
   ) u_dispatch (
      .clk_in     (clk_in),
      .rst        (rst),
      .fifo_valid (fifo_valid),
      .fifo_src   (fifo_src),
      .fifo_data  (fifo_data),
      .fifo_pop   (fifo_pop),
      .cfg_wr     (cfg_wr),
      .cfg_addr   (cfg_addr),
      .cfg_chan   (cfg_chan),
      .cfg_data   (cfg_data),
      .instr_dv   (instr_dv),
      .instr_chan (instr_chan),
      .instr_data (instr_data)
   );

   // Each channel learns its own index through CHAN_ID
   for (genvar g = 0; g < N_CHAN; g++) begin : g_chan
      pid_channel #(
         .CHAN_ID (g),
         .W_CHAN  (W_CHAN)
      ) u_chan (
         .clk_in     (clk_in),
         .rst        (rst),
         .instr_dv   (instr_dv),
         .instr_chan (instr_chan),
         .instr_data (instr_data),
         .cfg_wr     (cfg_wr),
         .cfg_addr   (cfg_addr),
         .cfg_chan   (cfg_chan),
         .cfg_data   (cfg_data),
         .res_dv     (res_dv[g]),
         .res_value  (res_value[g])
      );
   end

   result_collector #(
      .N_CHAN (N_CHAN),
      .W_CHAN (W_CHAN)
   ) u_collector (
      .clk_in     (clk_in),
      .rst        (rst),
      .res_dv     (res_dv),
      .res_value  (res_value),
      .dv_out     (dv_out),
      .chan_out   (chan_out),
      .result_out (result_out)
   );

endmodule

`default_nettype wire

//--- sim/pid_tb_model.svh
`ifndef PID_TB_MODEL_SVH
`define PID_TB_MODEL_SVH
`default_nettype none

// ---------------------------------------------------------------------------
// Reference model, stepped once per rising edge from the same stimulus
// ---------------------------------------------------------------------------

// Mirrored routing table and coefficients
logic [W_SRC-1:0] ref_src [N_CHAN];
logic [N_CHAN-1:0] ref_null;
logic [N_CHAN-1:0] ref_en;
logic signed [W_DATA-1:0] ref_sp [N_CHAN];
logic signed [W_GAIN-1:0] ref_gain [N_CHAN];
int ref_integ [N_CHAN];

// Words held by the input buffer, oldest first
logic [W_SRC-1:0] word_src [$];
logic signed [W_DATA-1:0] word_data [$];
logic [N_CHAN-1:0] served_map;
logic head_valid;
logic ovf_exp;

// Results in the order the dispatcher issues them
int exp_chan [$];
int exp_res [$];

function automatic void clear_model();
   for (int ch = 0; ch < N_CHAN; ch++) begin
      ref_src[ch] = '0;
      ref_sp[ch] = '0;
      ref_gain[ch] = '0;
      ref_integ[ch] = 0;
   end
   ref_null = '1;
   ref_en = '0;
   served_map = '0;
   head_valid = 1'b0;
   word_src.delete();
   word_data.delete();
   exp_chan.delete();
   exp_res.delete();
endfunction

// Error first, then the wrapping integrator, then gain times error on top.
// Plain int arithmetic wraps at 32 bits just like the result
function automatic void issue_result(input int ch, input logic signed [W_DATA-1:0] data);
   int err;
   err = int'(data) - int'(ref_sp[ch]);
   ref_integ[ch] = ref_integ[ch] + err;
   exp_chan.push_back(ch);
   exp_res.push_back(int'(ref_gain[ch]) * err + ref_integ[ch]);
endfunction

// One edge of buffer and dispatcher behavior, returns 1 when a word is dropped
function automatic logic step_model();
   logic found;
   logic pop;
   int sel;
   int held;
   found = 1'b0;
   pop = 1'b0;
   sel = 0;
   held = word_src.size();
   if (head_valid) begin
      // Lowest channel listening to the head source that has not had its slot
      for (int ch = 0; ch < N_CHAN; ch++) begin
         if (!found && !ref_null[ch] && ref_src[ch] == word_src[0] && !served_map[ch]) begin
            found = 1'b1;
            sel = ch;
         end
      end
      if (found) begin
         served_map[sel] = 1'b1;
         if (ref_en[sel]) begin
            issue_result(sel, word_data[0]);
         end
      end else begin
         pop = 1'b1;
      end
   end
   if (!found) begin
      served_map = '0;
   end
   // A word shows at the head one edge after it was written and leaves on its pop
   head_valid = (held - int'(pop)) > 0;
   if (pop) begin
      word_src.delete(0);
      word_data.delete(0);
   end
   if (dv_in && held < FIFO_DEPTH) begin
      word_src.push_back(src_in);
      word_data.push_back(data_in);
   end
   return dv_in && held >= FIFO_DEPTH;
endfunction

// The same written word is a route or a coefficient pair depending on address
function automatic void apply_cfg();
   cfg_word_u w;
   w = cfg_data;
   if (cfg_wr && cfg_addr == CFG_ADDR_ROUTE) begin
      ref_src[cfg_chan] = w.route.src;
      ref_null[cfg_chan] = w.route.null_src;
      ref_en[cfg_chan] = w.route.en;
   end else if (cfg_wr && cfg_addr == CFG_ADDR_COEF) begin
      ref_sp[cfg_chan] = w.coef.setpoint;
      ref_gain[cfg_chan] = w.coef.gain;
   end
endfunction

`default_nettype wire
`endif

//--- sim/pid_tb.sv
`default_nettype none

// Directed testbench for the PID dispatch subsystem
// The model follows the DUT edge by edge from the same stimulus, and the
// monitor checks every result strobe and every overflow pulse against it
module pid_tb
   import pid_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_CHAN = 8;
   localparam int FIFO_DEPTH = 16;
   localparam int W_CHAN = 3;
   localparam int CLK_PERIOD = 40;
   localparam int RESET_CYCLES = 10;
   // Long enough to overrun the buffer with a four-channel source
   localparam int BURST = FIFO_DEPTH + 8;
   // Cycle budget per test, the overrun burst needs about five cycles a word
   localparam int TEST_CYCLES = RESET_CYCLES + 60 + 40 + 50 + 40 + BURST * 6 + 40;

   logic clk_in = 1'b0;
   logic rst;
   logic dv_in;
   logic [W_SRC-1:0] src_in;
   logic signed [W_DATA-1:0] data_in;
   logic cfg_wr;
   logic [W_CFG_ADDR-1:0] cfg_addr;
   logic [W_CHAN-1:0] cfg_chan;
   logic [W_CFG-1:0] cfg_data;
   logic dv_out;
   logic [W_CHAN-1:0] chan_out;
   logic signed [W_RESULT-1:0] result_out;
   logic overflow;

   logic [31:0] lcg_state = 32'h33a9_4cee;
   int n_results = 0;
   int n_ovf = 0;
   // Words the model dropped, counted from its own prediction
   int n_drop = 0;

   `include "pid_tb_model.svh"

   pid_top #(
      .N_CHAN     (N_CHAN),
      .FIFO_DEPTH (FIFO_DEPTH),
      .W_CHAN     (W_CHAN)
   ) uut (
      .clk_in     (clk_in),
      .rst        (rst),
      .dv_in      (dv_in),
      .src_in     (src_in),
      .data_in    (data_in),
      .cfg_wr     (cfg_wr),
      .cfg_addr   (cfg_addr),
      .cfg_chan   (cfg_chan),
      .cfg_data   (cfg_data),
      .dv_out     (dv_out),
      .chan_out   (chan_out),
      .result_out (result_out),
      .overflow   (overflow)
   );

   always #(CLK_PERIOD / 2) clk_in = ~clk_in;

   // ---------------------------------------------------------------------------
   // Helpers
   // ---------------------------------------------------------------------------
   task automatic stop_on_error();
      $display("Testbench failed");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name,
                  $signed(expected), $signed(actual));
         stop_on_error();
      end
   endtask

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [W_CFG-1:0] route_word(input logic en, input logic nul,
                                                   input logic [W_SRC-1:0] src);
      cfg_word_u w;
      w = '0;
      w.route.en = en;
      w.route.null_src = nul;
      w.route.src = src;
      return w;
   endfunction

   function automatic logic [W_CFG-1:0] coef_word(input logic signed [W_DATA-1:0] sp,
                                                  input logic signed [W_GAIN-1:0] gain);
      cfg_word_u w;
      w.coef.setpoint = sp;
      w.coef.gain = gain;
      return w;
   endfunction

   task automatic write_cfg(input logic [W_CFG_ADDR-1:0] addr, input logic [W_CHAN-1:0] ch,
                            input logic [W_CFG-1:0] data);
      @(posedge clk_in);
      cfg_wr <= 1'b1;
      cfg_addr <= addr;
      cfg_chan <= ch;
      cfg_data <= data;
      @(posedge clk_in);
      cfg_wr <= 1'b0;
   endtask

   // Leaves dv_in high so that calls in a row make a back-to-back burst
   task automatic send_sample(input logic [W_SRC-1:0] src);
      logic [31:0] r;
      r = lcg_next();
      @(posedge clk_in);
      dv_in <= 1'b1;
      src_in <= src;
      data_in <= r[W_DATA-1:0];
   endtask

   // Ends any burst, then waits until the buffer is empty and every result is out
   task automatic wait_idle();
      @(posedge clk_in);
      dv_in <= 1'b0;
      do begin
         @(posedge clk_in);
      end while (word_src.size() != 0 || exp_chan.size() != 0);
      repeat (3) @(posedge clk_in);
   endtask

   // ---------------------------------------------------------------------------
   // Model stepping, monitor and watchdog
   // ---------------------------------------------------------------------------
   always @(posedge clk_in) begin
      if (rst) begin
         clear_model();
         ovf_exp <= 1'b0;
      end else begin
         ovf_exp <= step_model();
         apply_cfg();
      end
   end

   always @(posedge clk_in) begin
      if (!rst) begin
         check_value("overflow", 32'(ovf_exp), 32'(overflow));
         n_ovf += int'(overflow);
         n_drop += int'(ovf_exp);
         if (dv_out) begin
            if (exp_chan.size() == 0) begin
               $display("Result strobe from channel %0d at %0t ns with no result expected",
                        chan_out, $time);
               stop_on_error();
            end else begin
               check_value("chan_out", exp_chan.pop_front(), 32'(chan_out));
               check_value("result_out", exp_res.pop_front(), result_out);
               n_results++;
            end
         end
      end
   end

   initial begin
      #(2 * TEST_CYCLES * CLK_PERIOD);
      $display("Watchdog expired before the tests finished");
      stop_on_error();
   end

   // ---------------------------------------------------------------------------
   // Directed tests
   // ---------------------------------------------------------------------------
   // Nothing is routed yet, so every word drains in one cycle and never overflows
   task automatic idle_after_reset();
      for (int i = 0; i < 2 * FIFO_DEPTH; i++) begin
         send_sample(W_SRC'(i));
      end
      wait_idle();
      check_value("result count", 0, n_results);
      check_value("overflow count", 0, n_ovf);
   endtask

   task automatic single_route();
      int start;
      start = n_results;
      write_cfg(CFG_ADDR_ROUTE, 3'd2, route_word(1'b1, 1'b0, 5'd3));
      write_cfg(CFG_ADDR_COEF, 3'd2, coef_word(18'sd1000, 14'sd3));
      for (int i = 0; i < 4; i++) begin
         send_sample(5'd3);
         wait_idle();
      end
      check_value("result count", 4, n_results - start);
   endtask

   // Three channels on one source, each with its own coefficients
   task automatic fanout_order();
      int start;
      start = n_results;
      write_cfg(CFG_ADDR_ROUTE, 3'd6, route_word(1'b1, 1'b0, 5'd7));
      write_cfg(CFG_ADDR_ROUTE, 3'd1, route_word(1'b1, 1'b0, 5'd7));
      write_cfg(CFG_ADDR_ROUTE, 3'd4, route_word(1'b1, 1'b0, 5'd7));
      write_cfg(CFG_ADDR_COEF, 3'd1, coef_word(-18'sd500, -14'sd2));
      write_cfg(CFG_ADDR_COEF, 3'd4, coef_word(18'sd2000, 14'sd5));
      write_cfg(CFG_ADDR_COEF, 3'd6, coef_word(18'sd0, 14'sd1));
      for (int i = 0; i < 3; i++) begin
         send_sample(5'd7);
      end
      wait_idle();
      check_value("result count", 9, n_results - start);
   endtask

   // Channel 5 joins source 7 while disabled and must stay silent
   task automatic disabled_channel();
      int start;
      start = n_results;
      write_cfg(CFG_ADDR_COEF, 3'd5, coef_word(18'sd100, 14'sd7));
      write_cfg(CFG_ADDR_ROUTE, 3'd5, route_word(1'b0, 1'b0, 5'd7));
      for (int i = 0; i < 3; i++) begin
         send_sample(5'd7);
      end
      wait_idle();
      check_value("result count", 9, n_results - start);
   endtask

   // Every word the model accepts from the burst yields three results
   task automatic fifo_overrun();
      int start;
      int ovf_start;
      int drop_start;
      start = n_results;
      ovf_start = n_ovf;
      drop_start = n_drop;
      for (int i = 0; i < BURST; i++) begin
         send_sample(5'd7);
      end
      wait_idle();
      assert (n_ovf > ovf_start) else begin
         $display("No overflow pulse during a burst longer than the FIFO");
         stop_on_error();
      end
      check_value("result count", 3 * (BURST - (n_drop - drop_start)), n_results - start);
   endtask

   // Channel 1 moves to source 9 and channel 4 gets new coefficients
   task automatic live_reconfig();
      int start;
      start = n_results;
      write_cfg(CFG_ADDR_ROUTE, 3'd1, route_word(1'b1, 1'b0, 5'd9));
      write_cfg(CFG_ADDR_COEF, 3'd4, coef_word(-18'sd3000, -14'sd7));
      send_sample(5'd9);
      wait_idle();
      check_value("result count", 1, n_results - start);
      send_sample(5'd7);
      wait_idle();
      check_value("result count", 3, n_results - start);
   endtask

   initial begin
      rst = 1'b1;
      dv_in = 1'b0;
      src_in = '0;
      data_in = '0;
      cfg_wr = 1'b0;
      cfg_addr = '0;
      cfg_chan = '0;
      cfg_data = '0;
      repeat (RESET_CYCLES) @(posedge clk_in);
      rst <= 1'b0;
      idle_after_reset();
      single_route();
      fanout_order();
      disabled_channel();
      fifo_overrun();
      live_reconfig();
      @(posedge clk_in);
      if (exp_chan.size() != 0 || word_src.size() != 0) begin
         $display("Expected results were still outstanding at the end of the run");
         stop_on_error();
      end else begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+sim
src/pid_pkg.sv
src/adc_fifo.sv
src/instr_dispatch.sv
src/pid_channel.sv
src/result_collector.sv
src/pid_top.sv
sim/pid_tb.sv

//--- Makefile
# Verilator build for the PID dispatch subsystem
# Any variable can be overridden on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= pid_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard src/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# A failing check ends in $fatal, which gives a non-zero exit status
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
